/* sources.f */
bridge_pkg.sv
chip_bus_if.sv
bus_timing_gen.sv
bridge_cfg_regs.sv
m68k_bridge.sv
chip_bus_target.sv
bridge_top.sv
bridge_checker.sv
bridge_tb.sv

/* run.sh */
#!/bin/bash
# build the bridge testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module bridge_tb -f sources.f \
  -o sim_bridge > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_bridge > sim.log 2>&1 || echo "simulation stopped early, CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

/* bridge_tb.sv */
// --------------------
// bridge testbench
// directed cpu, peripheral, host and speed-mode tests
// --------------------
`timescale 1ns/1ps

module bridge_tb;

  localparam int mem_aw    = 8;
  localparam int nrdy_wait = 3;     // stretches every new access past the default
  localparam int ack_limit = 200;   // clocks until an acknowledge must come
  localparam int hold_cyc  = 6;     // strobe held after the acknowledge
  localparam int gap_cyc   = 8;     // idle clocks between bus cycles
  localparam int n_tests   = 5;
  localparam int worst_cyc = 3000;  // clocks of the longest test
  localparam longint watchdog_ns = 64'(40) * (16 + n_tests * worst_cyc);

  typedef logic [bridge_pkg::addr_w:1]   addr_t;
  typedef logic [bridge_pkg::data_w-1:0] word_t;

  logic                 clk = 1'b0;
  logic                 _as_and_cs;
  logic                 _as;
  logic                 _uds;
  logic                 _lds;
  logic                 r_w;
  addr_t                address;
  word_t                cpudatain;
  word_t                data;
  logic                 _dtack;
  logic                 host_cs;
  addr_t                host_adr;
  logic                 host_we;
  logic [1:0]           host_bs;
  word_t                host_wdat;
  word_t                host_rdat;
  logic                 host_ack;
  logic                 cfg_we;
  bridge_pkg::cfg_reg_e cfg_sel;
  logic [3:0]           cfg_wdat;
  logic                 turbo;
  logic                 bls;

  word_t      shadow [2**mem_aw];  // expected memory contents
  logic [1:0] model_slot;          // own 7 MHz slot count
  int         model_phase;         // own e clock phase
  int         ack_wait;            // clocks from _as low to _dtack low
  int         ack_phase;           // model phase seen at the acknowledge
  logic       bls_seen;            // cpu flagged as waiting on chip memory
  int         chk_cnt = 0;
  int         err_cnt = 0;

  bridge_top #(
    .mem_aw    (mem_aw),
    .nrdy_wait (nrdy_wait)
  ) dut (.*);

  always #20 clk = ~clk;  // 40 ns period

  // --------------------
  // e clock phase model stepping once per four clocks from reset
  always @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      model_slot  <= 2'd0;
      model_phase <= 0;
    end else begin
      model_slot <= model_slot + 2'd1;
      if (model_slot == 2'd0) begin
        model_phase <= (model_phase + 1) % bridge_pkg::eclk_phases;
      end
    end
  end

  task automatic expect_equal(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    err_cnt++;
    $display("At %0d ns something went wrong: %s", $time, what);
  endtask

  function automatic void store_word(input addr_t adr, input logic [1:0] strb,
                                     input word_t wdat);
    if (strb[1]) begin
      shadow[adr[mem_aw:1]][15:8] = wdat[15:8];
    end
    if (strb[0]) begin
      shadow[adr[mem_aw:1]][7:0] = wdat[7:0];
    end
  endfunction

  task automatic cfg_write(input bridge_pkg::cfg_reg_e sel, input logic [3:0] val);
    cfg_sel  = sel;
    cfg_wdat = val;
    cfg_we   = 1'b1;
    @(negedge clk);
    cfg_we   = 1'b0;
  endtask

  // --------------------
  // cpu bus cycle in two halves so the speed test can act mid-cycle
  task automatic cpu_start(input logic wr, input addr_t adr, input logic [1:0] strb,
                           input word_t wdat);
    expect_equal("_dtack before _as fell", _dtack, 1'b1);
    address   = adr;
    r_w       = ~wr;
    cpudatain = wdat;
    _uds      = ~strb[1];
    _lds      = ~strb[0];
    _as       = 1'b0;
  endtask

  task automatic cpu_finish(output word_t rdat);
    ack_wait = 0;
    bls_seen = 1'b0;
    while (_dtack && ack_wait < ack_limit) begin
      @(negedge clk);
      ack_wait++;
      if (bls) begin
        bls_seen = 1'b1;
      end
    end
    if (_dtack) begin
      report_failure("_dtack never fell after _as went low");
    end else begin
      ack_phase = model_phase;
      repeat (hold_cyc) @(negedge clk);  // transfer slot lands here
    end
    rdat = data;
    _as  = 1'b1;
    _uds = 1'b1;
    _lds = 1'b1;
    r_w  = 1'b1;
    @(negedge clk);
    expect_equal("_dtack one clock after _as rose", _dtack, 1'b1);
    repeat (gap_cyc) @(negedge clk);
  endtask

  task automatic cpu_access(input logic wr, input addr_t adr, input logic [1:0] strb,
                            input word_t wdat, output word_t rdat);
    cpu_start(wr, adr, strb, wdat);
    cpu_finish(rdat);
  endtask

  task automatic host_access(input logic wr, input addr_t adr, input logic [1:0] bs,
                             input word_t wdat, output word_t rdat);
    int waited;
    host_adr  = adr;
    host_we   = wr;
    host_bs   = bs;
    host_wdat = wdat;
    host_cs   = 1'b1;
    waited    = 0;
    while (!host_ack && waited < ack_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!host_ack) begin
      report_failure("host_ack never rose during a host access");
    end else begin
      expect_equal("_dtack while halted", _dtack, 1'b1);  // cpu kept waiting
      repeat (hold_cyc) @(negedge clk);
    end
    rdat    = host_rdat;
    host_cs = 1'b0;
    host_we = 1'b0;
    @(negedge clk);
    expect_equal("host_ack after host_cs fell", host_ack, 1'b0);
    repeat (gap_cyc) @(negedge clk);
  endtask

  // --------------------
  // tests
  task automatic test_word_rw();
    addr_t adr;
    word_t wdat;
    word_t rdat;
    for (int i = 0; i < 4; i++) begin
      adr  = addr_t'(32'h20 + i);
      wdat = word_t'($urandom);
      cpu_access(1'b1, adr, 2'b11, wdat, rdat);
      store_word(adr, 2'b11, wdat);
    end
    for (int i = 0; i < 4; i++) begin
      adr = addr_t'(32'h20 + i);
      cpu_access(1'b0, adr, 2'b11, '0, rdat);
      expect_equal("word read", rdat, shadow[adr[mem_aw:1]]);
    end
    for (int i = 0; i < 2; i++) begin  // upper lane, then lower lane
      adr  = addr_t'(32'h20 + i);
      wdat = word_t'($urandom);
      cpu_access(1'b1, adr, (i == 0) ? 2'b10 : 2'b01, wdat, rdat);
      store_word(adr, (i == 0) ? 2'b10 : 2'b01, wdat);
      cpu_access(1'b0, adr, 2'b11, '0, rdat);
      expect_equal("read after byte write", rdat, shadow[adr[mem_aw:1]]);
    end
  endtask

  task automatic test_dtack_timing();
    word_t rdat;
    word_t wdat;
    repeat (12) begin
      @(negedge clk);
      expect_equal("_dtack while bus idle", _dtack, 1'b1);
    end
    expect_equal("host_ack while bus idle", host_ack, 1'b0);
    expect_equal("bls while bus idle", bls, 1'b0);
    wdat = word_t'($urandom);
    cpu_access(1'b1, addr_t'(32'h40), 2'b11, wdat, rdat);  // new address holds nrdy
    store_word(addr_t'(32'h40), 2'b11, wdat);
    expect_equal("cycle stretched by nrdy", ack_wait >= (nrdy_wait - 1) * 4, 1'b1);
    expect_equal("bls while cpu waited on memory", bls_seen, 1'b1);
    cpu_access(1'b0, addr_t'(32'h40), 2'b11, '0, rdat);
    expect_equal("read after stretched write", rdat, wdat);
  endtask

  task automatic test_periph();
    addr_t adr;
    word_t rdat;
    for (int i = 0; i < 3; i++) begin
      repeat ($urandom_range(0, 23)) @(negedge clk);  // vary the start phase
      adr = {bridge_pkg::periph_base, 19'(2 * i + 1)};
      cpu_access(1'b0, adr, 2'b11, '0, rdat);
      expect_equal("e clock phase at peripheral _dtack", ack_phase, 8);
      expect_equal("bls during peripheral cycle", bls_seen, 1'b0);
    end
  endtask

  task automatic test_host();
    addr_t hadr;
    word_t wdat;
    word_t rdat;
    hadr = addr_t'(32'h30);
    cfg_write(bridge_pkg::CFG_HALT, 4'h1);  // takes effect while _as is high
    repeat (gap_cyc) @(negedge clk);
    address   = addr_t'(32'h20);  // cpu write that must not land
    r_w       = 1'b0;
    cpudatain = ~shadow[8'h20];
    _uds      = 1'b0;
    _lds      = 1'b0;
    _as       = 1'b0;
    wdat = word_t'($urandom);
    host_access(1'b1, hadr, 2'b11, wdat, rdat);
    store_word(hadr, 2'b11, wdat);
    host_access(1'b0, hadr, 2'b11, '0, rdat);
    expect_equal("host word read", rdat, shadow[hadr[mem_aw:1]]);
    wdat = word_t'($urandom);
    host_access(1'b1, hadr, 2'b10, wdat, rdat);  // upper byte only
    store_word(hadr, 2'b10, wdat);
    host_access(1'b0, hadr, 2'b11, '0, rdat);
    expect_equal("host read after byte write", rdat, shadow[hadr[mem_aw:1]]);
    host_access(1'b0, addr_t'(32'h20), 2'b11, '0, rdat);
    expect_equal("word the cpu tried to write", rdat, shadow[8'h20]);
    _as  = 1'b1;
    _uds = 1'b1;
    _lds = 1'b1;
    r_w  = 1'b1;
    cfg_write(bridge_pkg::CFG_HALT, 4'h0);
    repeat (gap_cyc) @(negedge clk);
    cpu_access(1'b0, hadr, 2'b11, '0, rdat);
    expect_equal("cpu read of host data", rdat, shadow[hadr[mem_aw:1]]);
  endtask

  task automatic test_speed();
    word_t rdat;
    cpu_start(1'b0, addr_t'(32'h21), 2'b11, '0);
    cfg_write(bridge_pkg::CFG_SPEED, 4'h1);  // request while _as low
    repeat (gap_cyc) @(negedge clk);
    expect_equal("turbo during cpu cycle", turbo, 1'b0);
    cpu_finish(rdat);
    expect_equal("read during speed change", rdat, shadow[8'h21]);
    expect_equal("turbo after _as rose", turbo, 1'b1);
    cfg_write(bridge_pkg::CFG_SPEED, 4'h0);
    repeat (gap_cyc) @(negedge clk);
    expect_equal("turbo back to normal", turbo, 1'b0);
  endtask

  // --------------------
  // watchdog
  initial begin
    #(watchdog_ns);
    $display("watchdog: the run did not finish within %0d ns", watchdog_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hdbe7));
    _as_and_cs = 1'b1;
    _as        = 1'b1;
    _uds       = 1'b1;
    _lds       = 1'b1;
    r_w        = 1'b1;
    address    = '0;
    cpudatain  = '0;
    host_cs    = 1'b0;
    host_adr   = '0;
    host_we    = 1'b0;
    host_bs    = 2'b00;
    host_wdat  = '0;
    cfg_we     = 1'b0;
    cfg_sel    = bridge_pkg::CFG_SPEED;
    cfg_wdat   = 4'h0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    _as_and_cs = 1'b0;
    repeat (4) @(negedge clk);
    test_word_rw();
    test_dtack_timing();
    test_periph();
    test_host();
    test_speed();
    $display("checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* bridge_checker.sv */
// --------------------
// bridge checker
// concurrent checks on _dtack, vma and the chipset strobes
// --------------------
`timescale 1ns/1ps

module bridge_checker (
  input logic                               clk,
  input logic                               _as_and_cs,
  input logic                               clk7_en,
  input logic [bridge_pkg::eclk_phases-1:0] eclk,
  input logic                               vma,
  input logic                               _dtack,
  input logic                               rd,
  input logic                               hwr,
  input logic                               lwr
);

  // no acknowledge while in reset
  a_dtack_reset: assert property (@(posedge clk) _as_and_cs |-> _dtack)
    else $error("_dtack low during reset");

  // vma moves only on a 7 MHz edge, so once per slot
  a_vma_slot: assert property (@(posedge clk) disable iff (_as_and_cs)
    !clk7_en |=> $stable(vma))
    else $error("vma changed between 7 MHz edges");

  a_vma_set: assert property (@(posedge clk) disable iff (_as_and_cs)
    $rose(vma) |-> $past(eclk[3]))  // set only out of phase 3
    else $error("vma set outside e clock phase 3");

  a_vma_clr: assert property (@(posedge clk) disable iff (_as_and_cs)
    $fell(vma) |-> $past(eclk[9]))  // cleared only out of phase 9
    else $error("vma cleared outside e clock phase 9");

  // read and write strobes are exclusive
  a_rd_wr: assert property (@(posedge clk) disable iff (_as_and_cs)
    !(rd && (hwr || lwr)))
    else $error("read and write strobes together on the chipset bus");

endmodule

bind m68k_bridge bridge_checker u_checker (
  .clk        (clk),
  ._as_and_cs (_as_and_cs),
  .clk7_en    (clk7_en),
  .eclk       (eclk),
  .vma        (vma),
  ._dtack     (_dtack),
  .rd         (bus.rd),
  .hwr        (bus.hwr),
  .lwr        (bus.lwr)
);

/* bridge_top.sv */
// --------------------
// cpu bridge top
// timing, config registers, bridge and chipset target
// --------------------
`timescale 1ns/1ps

module bridge_top #(
  parameter int mem_aw    = 8,
  parameter int nrdy_wait = 2
) (
  input  logic                          clk,
  input  logic                          _as_and_cs,
  // cpu side
  input  logic                          _as,
  input  logic                          _uds,
  input  logic                          _lds,
  input  logic                          r_w,
  input  logic [bridge_pkg::addr_w:1]   address,
  input  logic [bridge_pkg::data_w-1:0] cpudatain,
  output logic [bridge_pkg::data_w-1:0] data,
  output logic                          _dtack,
  // host side
  input  logic                          host_cs,
  input  logic [bridge_pkg::addr_w:1]   host_adr,
  input  logic                          host_we,
  input  logic [1:0]                    host_bs,
  input  logic [bridge_pkg::data_w-1:0] host_wdat,
  output logic [bridge_pkg::data_w-1:0] host_rdat,
  output logic                          host_ack,
  // config write port
  input  logic                          cfg_we,
  input  bridge_pkg::cfg_reg_e          cfg_sel,
  input  logic [3:0]                    cfg_wdat,
  output logic                          turbo,
  output logic                          bls
);

  logic                               clk7_en;
  logic                               clk7n_en;
  logic                               c1;
  logic                               c3;
  logic                               cck;
  logic [bridge_pkg::eclk_phases-1:0] eclk;
  logic                               vpa;
  logic                               dbr;
  logic                               dbs;
  logic                               xbs;
  logic                               nrdy;
  logic                               cpu_speed;
  logic                               cpu_halt;
  logic [3:0]                         memory_config;

  chip_bus_if bus ();  // chipset bus

  bus_timing_gen u_timing (.*);

  bridge_cfg_regs u_cfg (.*);

  m68k_bridge u_bridge (.*);

  chip_bus_target #(
    .mem_aw    (mem_aw),
    .nrdy_wait (nrdy_wait)
  ) u_target (.*);

endmodule

/* chip_bus_target.sv */
// --------------------
// chipset target model
// word memory, cia window on vpa, dma steal and not-ready sources
// --------------------
`timescale 1ns/1ps

module chip_bus_target #(
  parameter int mem_aw    = 8,
  parameter int nrdy_wait = 2
) (
  input  logic        clk,
  input  logic        _as_and_cs,
  input  logic        clk7_en,
  input  logic        cck,
  output logic        vpa,
  output logic        dbr,
  output logic        dbs,
  output logic        xbs,
  output logic        nrdy,
  chip_bus_if.target  bus
);

  localparam int cnt_w = $clog2(nrdy_wait + 2);  // at least one bit

  logic [bridge_pkg::data_w-1:0] mem [2**mem_aw];
  logic [mem_aw-1:0]             idx;
  logic                          periph;     // address in the cia window
  logic                          dma_slot;   // alternates over cck-low slots
  logic                          addr_new;
  logic [bridge_pkg::addr_w:1]   last_addr;
  logic [cnt_w-1:0]              cnt;        // nrdy slots left
  bridge_pkg::target_state_e     state;

  assign idx      = bus.address_out[mem_aw:1];
  assign periph   = (bus.address_out[bridge_pkg::addr_w -: 4] == bridge_pkg::periph_base);
  assign addr_new = (bus.address_out != last_addr);
  assign vpa      = periph;
  assign dbs      = ~periph;                          // chip memory is slow
  assign xbs      = ~bus.address_out[bridge_pkg::addr_w];  // lower half shared with dma
  assign dbr      = ~cck & dma_slot;
  assign nrdy     = (state == bridge_pkg::T_WAIT) && (cnt != '0);
  assign bus.data_in = mem[idx];

  // dma takes every other cck-low slot
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      dma_slot <= 1'b0;
    end else if (clk7_en && cck) begin
      dma_slot <= ~dma_slot;
    end
  end

  // --------------------
  // not-ready sequencing per new access
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      state     <= bridge_pkg::T_IDLE;
      cnt       <= '0;
      last_addr <= '0;
    end else begin
      case (state)
        bridge_pkg::T_IDLE: begin
          if (addr_new) begin
            state     <= bridge_pkg::T_WAIT;
            cnt       <= cnt_w'(nrdy_wait);
            last_addr <= bus.address_out;
          end
        end
        bridge_pkg::T_WAIT: begin
          if (cnt == '0) begin
            state <= bridge_pkg::T_DONE;
          end else if (clk7_en) begin
            cnt <= cnt - 1'b1;  // one per 7 MHz slot
          end
        end
        bridge_pkg::T_DONE: begin
          if (bus.rd || bus.hwr || bus.lwr) begin
            state <= bridge_pkg::T_IDLE;  // served, rearm on next address
          end else if (addr_new) begin
            state     <= bridge_pkg::T_WAIT;
            cnt       <= cnt_w'(nrdy_wait);
            last_addr <= bus.address_out;
          end
        end
        default: begin
          state <= bridge_pkg::T_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // byte-lane writes
  always_ff @(posedge clk) begin
    if (clk7_en && !periph) begin
      if (bus.hwr) begin
        mem[idx][15:8] <= bus.data_out[15:8];
      end
      if (bus.lwr) begin
        mem[idx][7:0] <= bus.data_out[7:0];
      end
    end
  end

endmodule

/* m68k_bridge.sv */
// --------------------
// 68000 bus bridge
// syncs cpu strobes onto the chipset bus, paces _dtack and vma,
// hands the bus to the host while halted
// --------------------
`timescale 1ns/1ps

module m68k_bridge (
  input  logic                               clk,
  input  logic                               _as_and_cs,
  input  logic                               clk7_en,
  input  logic                               clk7n_en,
  input  logic                               c1,
  input  logic                               c3,
  input  logic                               cck,
  input  logic [bridge_pkg::eclk_phases-1:0] eclk,
  input  logic                               vpa,
  input  logic                               dbr,
  input  logic                               dbs,
  input  logic                               xbs,
  input  logic                               nrdy,
  input  logic                               cpu_speed,
  input  logic                               cpu_halt,
  input  logic [3:0]                         memory_config,  // not decoded here
  input  logic                               _as,
  input  logic                               _uds,
  input  logic                               _lds,
  input  logic                               r_w,
  input  logic [bridge_pkg::addr_w:1]        address,
  input  logic [bridge_pkg::data_w-1:0]      cpudatain,
  input  logic                               host_cs,
  input  logic [bridge_pkg::addr_w:1]        host_adr,
  input  logic                               host_we,
  input  logic [1:0]                         host_bs,
  input  logic [bridge_pkg::data_w-1:0]      host_wdat,
  output logic                               turbo,
  output logic                               bls,
  output logic                               _dtack,
  output logic [bridge_pkg::data_w-1:0]      data,
  output logic [bridge_pkg::data_w-1:0]      host_rdat,
  output logic                               host_ack,
  chip_bus_if.master                         bus
);

  logic                          halt;      // host owns the bus
  logic                          lvpa;      // vpa at the last 7 MHz edge
  logic                          vma;       // valid memory address, cia cycles
  logic                          as_sel;    // strobe of the current owner
  logic                          ack_clr;   // async end of acknowledge
  logic                          l_as;
  logic                          l_rw;
  logic                          l_ta;      // acknowledge seen by the bus side
  logic                          l_uds;
  logic                          l_lds;
  logic                          as28;      // fast-sampled strobe, turbo path
  logic                          l_as28;
  logic                          ta_n;      // acknowledge flop, active low
  logic                          enable;    // transfer slot on the chipset bus
  logic [bridge_pkg::data_w-1:0] ldata_in;  // read data latch

  assign as_sel  = halt ? ~host_cs : _as;
  assign ack_clr = _as_and_cs | as_sel;

  // --------------------
  // mode flags, only between cpu cycles
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      halt  <= 1'b0;
      turbo <= 1'b0;
    end else if (clk7_en && _as) begin
      halt  <= cpu_halt;
      turbo <= cpu_speed;
    end
  end

  // --------------------
  // vpa and vma, set in phase 3, dropped in phase 9
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      lvpa <= 1'b0;
      vma  <= 1'b0;
    end else if (clk7_en) begin
      lvpa <= vpa;
      if (eclk[9]) begin
        vma <= 1'b0;
      end else if (eclk[3] && lvpa) begin
        vma <= 1'b1;
      end
    end
  end

  // --------------------
  // strobe sync
  // the cpu holds _as, strobes and data for a 7 MHz period after _dtack
  // falls, so the transfer slot lands before the cycle ends
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      l_as   <= 1'b1;
      l_rw   <= 1'b1;
      l_ta   <= 1'b1;
      l_as28 <= 1'b1;
    end else if (clk7_en) begin
      l_as   <= as_sel;
      l_rw   <= halt ? ~host_we : r_w;
      l_ta   <= ta_n;
      l_as28 <= as28;
    end
  end

  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      l_uds <= 1'b1;
      l_lds <= 1'b1;
      as28  <= 1'b1;
    end else begin
      l_uds <= halt ? ~host_bs[1] : _uds;  // every fast cycle
      l_lds <= halt ? ~host_bs[0] : _lds;
      as28  <= as_sel;
    end
  end

  // --------------------
  // acknowledge
  // memory: cck high, no dma steal; cia: vma set and phase 8
  always_ff @(posedge clk or posedge ack_clr) begin
    if (ack_clr) begin
      ta_n <= 1'b1;  // back high as soon as the strobe rises
    end else if (clk7n_en && !l_as && cck && !nrdy) begin
      if ((!vpa && !(dbr && dbs)) || (vpa && vma && eclk[8])) begin
        ta_n <= 1'b0;
      end
    end
  end

  assign _dtack   = ta_n | halt;   // cpu sees nothing while halted
  assign host_ack = ~ta_n & halt;

  // --------------------
  // chipset bus side
  // turbo cia accesses get no wait states
  assign enable = (~l_as & ~l_ta & ~cck & ~turbo)
                | (~l_as28 & l_ta & ~(dbr & xbs) & ~nrdy & turbo);

  assign bus.rd  = enable & l_rw;
  assign bus.hwr = enable & ~l_rw & ~l_uds;
  assign bus.lwr = enable & ~l_rw & ~l_lds;
  assign bls     = dbs & ~l_as & l_ta;  // cpu waiting on chip memory

  assign bus.address_out = halt ? host_adr : address;
  assign bus.data_out    = halt ? host_wdat : cpudatain;

  // read data mid-slot, c3 high and c1 low
  always_ff @(posedge clk) begin
    if (!c1 && c3 && enable) begin
      ldata_in <= bus.data_in;
    end
  end

  assign data      = ldata_in;
  assign host_rdat = ldata_in;  // same latch for both owners

endmodule

/* bridge_cfg_regs.sv */
// --------------------
// bridge config registers
// host-written speed request, halt request and memory config
// --------------------
`timescale 1ns/1ps

module bridge_cfg_regs (
  input  logic                 clk,
  input  logic                 _as_and_cs,
  input  logic                 cfg_we,
  input  bridge_pkg::cfg_reg_e cfg_sel,
  input  logic [3:0]           cfg_wdat,
  output logic                 cpu_speed,
  output logic                 cpu_halt,
  output logic [3:0]           memory_config
);

  // --------------------
  // write port
  // requests only, the bridge decides when they take effect
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      cpu_speed     <= 1'b0;  // normal 7 MHz mode
      cpu_halt      <= 1'b0;  // cpu owns the bus
      memory_config <= 4'd0;
    end else if (cfg_we) begin
      case (cfg_sel)
        bridge_pkg::CFG_SPEED: begin
          cpu_speed <= cfg_wdat[0];
        end
        bridge_pkg::CFG_HALT: begin
          cpu_halt <= cfg_wdat[0];
        end
        bridge_pkg::CFG_MEMCFG: begin
          memory_config <= cfg_wdat;  // whole nibble
        end
        default: ;  // unmapped select, write dropped
      endcase
    end
  end

endmodule

/* bus_timing_gen.sv */
// --------------------
// bus timing generator
// 7 MHz enables, c1/c3 quadrature, colour clock and ten-phase e clock
// --------------------
`timescale 1ns/1ps

module bus_timing_gen (
  input  logic                               clk,
  input  logic                               _as_and_cs,
  output logic                               clk7_en,
  output logic                               clk7n_en,
  output logic                               c1,
  output logic                               c3,
  output logic                               cck,
  output logic [bridge_pkg::eclk_phases-1:0] eclk
);

  logic [1:0] slot;  // fast slot within one 7 MHz period

  // --------------------
  // slot divider
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      slot <= 2'd0;
    end else begin
      slot <= slot + 2'd1;
    end
  end

  assign clk7_en  = (slot == 2'd0);     // one cycle in four
  assign clk7n_en = (slot == 2'd2);     // opposite 7 MHz edge
  assign c1       = ~slot[1];           // high in slots 0 and 1
  assign c3       = slot[1] ^ slot[0];  // high in slots 1 and 2

  // --------------------
  // colour clock and e clock ring
  // cck starts high so that it is high again in every even eclk phase,
  // phase 8 included, which the cia acknowledge depends on
  always_ff @(posedge clk or posedge _as_and_cs) begin
    if (_as_and_cs) begin
      cck  <= 1'b1;
      eclk <= {{(bridge_pkg::eclk_phases-1){1'b0}}, 1'b1};  // phase 0
    end else if (clk7_en) begin
      cck  <= ~cck;
      // one phase per 7 MHz period
      eclk <= {eclk[bridge_pkg::eclk_phases-2:0], eclk[bridge_pkg::eclk_phases-1]};
    end
  end

endmodule

/* chip_bus_if.sv */
// --------------------
// chipset bus
// synchronous enable-clocked bus between bridge and chipset target
// --------------------
`timescale 1ns/1ps

interface chip_bus_if;

  logic [bridge_pkg::addr_w:1]   address_out;  // word address from cpu or host
  logic [bridge_pkg::data_w-1:0] data_out;     // write data
  logic [bridge_pkg::data_w-1:0] data_in;      // read data, combinational
  logic                          rd;           // read strobe
  logic                          hwr;          // upper byte write
  logic                          lwr;          // lower byte write

  // strobes are levels, valid while the bridge enable holds
  modport master (
    output address_out,
    output data_out,
    output rd,
    output hwr,
    output lwr,
    input  data_in
  );

  modport target (
    input  address_out,
    input  data_out,
    input  rd,
    input  hwr,
    input  lwr,
    output data_in
  );

endinterface

/* bridge_pkg.sv */
// --------------------
// cpu bus bridge package
// shared widths, e clock size, peripheral window and enums
// --------------------
package bridge_pkg;

  // --------------------
  // bus widths
  localparam int addr_w = 23;       // word address, bits 23 down to 1
  localparam int data_w = 16;       // cpu and chipset data
  localparam int eclk_phases = 10;  // phases 0..5 low, 6..9 high

  // upper address nibble of the cia window, answered through vpa
  localparam logic [3:0] periph_base = 4'hb;

  // --------------------
  // host config registers
  typedef enum logic [1:0] {
    CFG_SPEED  = 2'd0,  // bit 0 requests turbo
    CFG_HALT   = 2'd1,  // bit 0 hands the bus to the host
    CFG_MEMCFG = 2'd2   // memory layout nibble
  } cfg_reg_e;

  // target access sequencing
  typedef enum logic [1:0] {
    T_IDLE = 2'd0,  // waiting for a new address
    T_WAIT = 2'd1,  // nrdy held for a few slots
    T_DONE = 2'd2   // ready, waiting for the transfer strobe
  } target_state_e;

  // Phases are one-hot in the eclk vector. The bridge looks at phase 3
  // to set vma, at phase 8 to acknowledge a cia cycle and at phase 9 to
  // drop vma again.

endpackage
